//--- rtl/mem_bus_pkg.sv
package mem_bus_pkg;

  //////////////////////////////////////////////////
  // shared memory bus geometry

  // data width and byte enables
  localparam int unsigned MemW = 64;
  localparam int unsigned MemBeW = MemW / 8;

  localparam int unsigned AddrW = 32;

  // byte offset of a 32-bit lane inside one bus word
  localparam int unsigned LaneOffW = 3;

  // outstanding request record
  localparam int unsigned OrderDepth = 32;
  localparam int unsigned OrderCntW = 5;

  // one bus request, 105 bits
  typedef struct packed {
    logic [AddrW-1:0]  addr;
    logic              we;
    logic [MemBeW-1:0] be;
    logic [MemW-1:0]   wdata;
  } mem_req_t;

endpackage

//--- rtl/host_port_pkg.sv
package host_port_pkg;

  //////////////////////////////////////////////////
  // host side data ports

  // scalar core word
  localparam int unsigned WordW = 32;
  localparam int unsigned WordBeW = WordW / 8;

  // id carried by every vector access
  localparam int unsigned VIdW = 3;

  // scalar request, 69 bits
  typedef struct packed {
    logic [mem_bus_pkg::AddrW-1:0] addr;
    logic                          we;
    logic [WordBeW-1:0]            be;
    logic [WordW-1:0]              wdata;
  } scalar_req_t;

  // vector request, full bus width plus id, 108 bits
  typedef struct packed {
    logic [mem_bus_pkg::AddrW-1:0]  addr;
    logic                           we;
    logic [mem_bus_pkg::MemBeW-1:0] be;
    logic [mem_bus_pkg::MemW-1:0]   wdata;
    logic [VIdW-1:0]                id;
  } vec_req_t;

endpackage

//--- rtl/scalar_lane_adapter.sv
`timescale 1ns/100ps

module scalar_lane_adapter
  import mem_bus_pkg::*;
  import host_port_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  scalar_req_t       sreq_i,
  input  logic              grant_i,
  input  logic [MemW-1:0]   rdata_i,
  output mem_req_t          wide_o,
  output logic [WordW-1:0]  word_o
);

  localparam int unsigned NumLanes = MemW / WordW;

  logic [LaneOffW-1:0] lane_off;
  logic [LaneOffW-1:0] lane_q;

  // byte offset of the word lane, low bits within the word dropped
  assign lane_off = sreq_i.addr[LaneOffW-1:0] & ~LaneOffW'(WordBeW - 1);

  //////////////////////////////////////////////////
  // request path

  always_comb begin
    wide_o.addr = sreq_i.addr;
    wide_o.we   = sreq_i.we;
    wide_o.be   = MemBeW'(sreq_i.be) << lane_off;
    // same word on every lane, be picks the right one
    for (int i = 0; i < NumLanes; i++) begin
      wide_o.wdata[WordW*i +: WordW] = sreq_i.wdata;
    end
  end

  //////////////////////////////////////////////////
  // response path

  // lane of the access in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_q <= '0;
    end else if (grant_i) begin
      lane_q <= lane_off;
    end
  end

  // byte offset times 8 gives the bit offset
  assign word_o = rdata_i[{lane_q, 3'b000} +: WordW];

endmodule

//--- rtl/data_arbiter.sv
`timescale 1ns/100ps

module data_arbiter
  import mem_bus_pkg::*;
  import host_port_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  // scalar port
  input  logic             sdata_req_i,
  input  scalar_req_t      sdata_i,
  output logic             sdata_gnt_o,
  output logic             sdata_rvalid_o,
  output logic [WordW-1:0] sdata_rdata_o,
  output logic             sdata_err_o,
  // vector port
  input  logic             vdata_req_i,
  input  vec_req_t         vdata_i,
  output logic             vdata_gnt_o,
  output logic             vdata_rvalid_o,
  output logic [MemW-1:0]  vdata_rdata_o,
  output logic [VIdW-1:0]  vdata_id_o,
  output logic             vdata_err_o,
  // vector unit state
  input  logic             vect_pending_load_i,
  input  logic             vect_pending_store_i,
  // towards the memory arbiter
  output logic             dreq_o,
  output mem_req_t         dreq_data_o,
  input  logic             dgnt_i,
  input  logic             drvalid_i,
  input  logic             derr_i,
  input  logic [MemW-1:0]  drdata_i
);

  logic            sdata_hold;
  logic            busy;
  logic            swait_q;
  logic            vwait_q;
  logic [VIdW-1:0] vid_q;
  mem_req_t        swide;

  // scalar word placed on its lane of the bus
  scalar_lane_adapter u_lane (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .sreq_i  (sdata_i),
    .grant_i (sdata_gnt_o),
    .rdata_i (drdata_i),
    .wide_o  (swide),
    .word_o  (sdata_rdata_o)
  );

  //////////////////////////////////////////////////
  // arbitration

  // keep scalar accesses behind pending vector memory traffic
  assign sdata_hold = vdata_req_i | vect_pending_store_i | (vect_pending_load_i & sdata_i.we);

  // one data access in flight at a time
  assign busy = swait_q | vwait_q;

  assign dreq_o      = ~busy & (vdata_req_i | (sdata_req_i & ~sdata_hold));
  assign dreq_data_o = vdata_req_i ? mem_req_t'({vdata_i.addr, vdata_i.we, vdata_i.be,
                                                 vdata_i.wdata}) : swide;

  assign vdata_gnt_o = dgnt_i & ~busy & vdata_req_i;
  assign sdata_gnt_o = dgnt_i & ~busy & sdata_req_i & ~sdata_hold;

  //////////////////////////////////////////////////
  // response tracking

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      swait_q <= 1'b0;
      vwait_q <= 1'b0;
    end else begin
      if (sdata_gnt_o) begin
        swait_q <= 1'b1;
      end else if (drvalid_i) begin
        swait_q <= 1'b0;
      end
      if (vdata_gnt_o) begin
        vwait_q <= 1'b1;
      end else if (drvalid_i) begin
        vwait_q <= 1'b0;
      end
    end
  end

  // id handed back with the vector response
  always_ff @(posedge clk_i) begin
    if (vdata_gnt_o) begin
      vid_q <= vdata_i.id;
    end
  end

  assign sdata_rvalid_o = swait_q & drvalid_i;
  assign sdata_err_o    = swait_q & derr_i;

  assign vdata_rvalid_o = vwait_q & drvalid_i;
  assign vdata_err_o    = vwait_q & derr_i;
  assign vdata_rdata_o  = drdata_i;
  assign vdata_id_o     = vid_q;

endmodule

//--- rtl/req_order_queue.sv
`timescale 1ns/100ps

module req_order_queue
  import mem_bus_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  logic                push_data_i,
  input  logic [LaneOffW-1:0] push_lane_i,
  input  logic                pop_i,
  output logic                head_data_o,
  output logic [LaneOffW-1:0] head_lane_o
);

  // source of one outstanding bus request
  typedef struct packed {
    logic                data;
    logic [LaneOffW-1:0] lane;
  } order_entry_t;

  order_entry_t                 entry_q [OrderDepth];
  order_entry_t                 new_entry;
  logic         [OrderCntW-1:0] cnt_q;
  logic         [OrderCntW-1:0] wr_idx;

  assign new_entry.data = push_data_i;
  assign new_entry.lane = push_lane_i;

  // entries move down one slot on a pop
  assign wr_idx = pop_i ? cnt_q - OrderCntW'(1) : cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (push_i && !pop_i) begin
      cnt_q <= cnt_q + OrderCntW'(1);
    end else if (pop_i && !push_i) begin
      cnt_q <= cnt_q - OrderCntW'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_i) begin
      for (int i = 0; i < OrderDepth - 1; i++) begin
        entry_q[i] <= entry_q[i+1];
      end
    end
    // written after the shift so it wins at wr_idx
    if (push_i) begin
      entry_q[wr_idx] <= new_entry;
    end
  end

  assign head_data_o = entry_q[0].data;
  assign head_lane_o = entry_q[0].lane;

endmodule

//--- rtl/mem_port_arbiter.sv
`timescale 1ns/100ps

module mem_port_arbiter
  import mem_bus_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // instruction fetch
  input  logic                          fetch_req_i,
  input  logic [AddrW-1:0]              fetch_addr_i,
  output logic                          fetch_gnt_o,
  output logic                          fetch_rvalid_o,
  output logic [host_port_pkg::WordW-1:0] fetch_rdata_o,
  output logic                          fetch_err_o,
  // data side
  input  logic                          dreq_i,
  input  mem_req_t                      dreq_data_i,
  output logic                          dgnt_o,
  output logic                          drvalid_o,
  output logic                          derr_o,
  output logic [MemW-1:0]               drdata_o,
  // memory bus
  output logic                          mem_req_o,
  output mem_req_t                      mem_o,
  input  logic                          mem_rvalid_i,
  input  logic                          mem_err_i,
  input  logic [MemW-1:0]               mem_rdata_i
);

  logic                head_data;
  logic [LaneOffW-1:0] head_lane;
  logic [LaneOffW-1:0] fetch_lane;

  //////////////////////////////////////////////////
  // request side

  // data always wins, the fetch waits
  assign dgnt_o      = dreq_i;
  assign fetch_gnt_o = fetch_req_i & ~dreq_i;
  assign mem_req_o   = fetch_req_i | dreq_i;

  always_comb begin
    mem_o = dreq_data_i;
    if (!dreq_i) begin
      mem_o.addr  = fetch_addr_i;
      mem_o.we    = 1'b0;
      mem_o.be    = '1;
      mem_o.wdata = '0;
    end
  end

  // word lane of the fetch address
  assign fetch_lane = {fetch_addr_i[LaneOffW-1:2], 2'b00};

  req_order_queue u_order (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (mem_req_o),
    .push_data_i (dreq_i),
    .push_lane_i (fetch_lane),
    .pop_i       (mem_rvalid_i),
    .head_data_o (head_data),
    .head_lane_o (head_lane)
  );

  //////////////////////////////////////////////////
  // response side

  assign drvalid_o = mem_rvalid_i & head_data;
  assign derr_o    = mem_err_i & head_data;
  assign drdata_o  = mem_rdata_i;

  assign fetch_rvalid_o = mem_rvalid_i & ~head_data;
  assign fetch_err_o    = mem_rvalid_i & ~head_data & mem_err_i;
  assign fetch_rdata_o  = mem_rdata_i[{head_lane, 3'b000} +: host_port_pkg::WordW];

endmodule

//--- rtl/vmem_subsys_top.sv
`timescale 1ns/100ps

module vmem_subsys_top
  import mem_bus_pkg::*;
  import host_port_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  // instruction fetch
  input  logic             fetch_req_i,
  input  logic [AddrW-1:0] fetch_addr_i,
  output logic             fetch_gnt_o,
  output logic             fetch_rvalid_o,
  output logic [WordW-1:0] fetch_rdata_o,
  output logic             fetch_err_o,
  // scalar data
  input  logic             sdata_req_i,
  input  scalar_req_t      sdata_i,
  output logic             sdata_gnt_o,
  output logic             sdata_rvalid_o,
  output logic [WordW-1:0] sdata_rdata_o,
  output logic             sdata_err_o,
  // vector data
  input  logic             vdata_req_i,
  input  vec_req_t         vdata_i,
  output logic             vdata_gnt_o,
  output logic             vdata_rvalid_o,
  output logic [MemW-1:0]  vdata_rdata_o,
  output logic [VIdW-1:0]  vdata_id_o,
  output logic             vdata_err_o,
  input  logic             vect_pending_load_i,
  input  logic             vect_pending_store_i,
  // memory bus
  output logic             mem_req_o,
  output mem_req_t         mem_o,
  input  logic             mem_rvalid_i,
  input  logic             mem_err_i,
  input  logic [MemW-1:0]  mem_rdata_i
);

  // merged data side between the two arbiters
  logic            dreq;
  mem_req_t        dreq_data;
  logic            dgnt;
  logic            drvalid;
  logic            derr;
  logic [MemW-1:0] drdata;

  data_arbiter u_data_arb (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .sdata_req_i          (sdata_req_i),
    .sdata_i              (sdata_i),
    .sdata_gnt_o          (sdata_gnt_o),
    .sdata_rvalid_o       (sdata_rvalid_o),
    .sdata_rdata_o        (sdata_rdata_o),
    .sdata_err_o          (sdata_err_o),
    .vdata_req_i          (vdata_req_i),
    .vdata_i              (vdata_i),
    .vdata_gnt_o          (vdata_gnt_o),
    .vdata_rvalid_o       (vdata_rvalid_o),
    .vdata_rdata_o        (vdata_rdata_o),
    .vdata_id_o           (vdata_id_o),
    .vdata_err_o          (vdata_err_o),
    .vect_pending_load_i  (vect_pending_load_i),
    .vect_pending_store_i (vect_pending_store_i),
    .dreq_o               (dreq),
    .dreq_data_o          (dreq_data),
    .dgnt_i               (dgnt),
    .drvalid_i            (drvalid),
    .derr_i               (derr),
    .drdata_i             (drdata)
  );

  mem_port_arbiter u_mem_arb (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_gnt_o    (fetch_gnt_o),
    .fetch_rvalid_o (fetch_rvalid_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .fetch_err_o    (fetch_err_o),
    .dreq_i         (dreq),
    .dreq_data_i    (dreq_data),
    .dgnt_o         (dgnt),
    .drvalid_o      (drvalid),
    .derr_o         (derr),
    .drdata_o       (drdata),
    .mem_req_o      (mem_req_o),
    .mem_o          (mem_o),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_err_i      (mem_err_i),
    .mem_rdata_i    (mem_rdata_i)
  );

endmodule

//--- bench/tb_mem_model.sv
`timescale 1ns/100ps

module tb_mem_model
  import mem_bus_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  mem_req_t        mem_i,
  output logic            rvalid_o,
  output logic [MemW-1:0] rdata_o,
  output logic            err_o
);

  localparam logic [31:0]      Seed  = 32'h35e59199;
  localparam logic [AddrW-1:0] ErrLo = 32'h0000_F000;
  localparam logic [AddrW-1:0] ErrHi = 32'h0000_FFFF;

  logic [MemW-1:0] store [logic [AddrW-1:0]];
  logic [MemW-1:0] data_q [$];
  logic            err_q [$];
  int unsigned     due_q [$];
  int unsigned     cycle;
  int unsigned     last_due;
  logic [31:0]     lfsr;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin : mem_proc
    logic [AddrW-1:0] wa;
    logic [MemW-1:0]  word;
    logic             err;
    int unsigned      due;
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      data_q.delete();
      err_q.delete();
      due_q.delete();
      cycle    = 0;
      last_due = 0;
      lfsr     = Seed;
    end else begin
      cycle++;
      if (req_i) begin
        wa   = {mem_i.addr[AddrW-1:3], 3'b000};
        err  = (mem_i.addr >= ErrLo) && (mem_i.addr <= ErrHi);
        // untouched words hold a pattern of their own address
        word = store.exists(wa) ? store[wa] : {~wa, wa};
        if (mem_i.we && !err) begin
          for (int b = 0; b < MemBeW; b++) begin
            if (mem_i.be[b]) begin
              word[b*8 +: 8] = mem_i.wdata[b*8 +: 8];
            end
          end
          store[wa] = word;
        end
        // latency 1 to 4, never before the previous answer
        lfsr = lfsr_next(lfsr);
        due  = cycle + 2 * lfsr[0];
        lfsr = lfsr_next(lfsr);
        due  = due + lfsr[0];
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        data_q.push_back(word);
        err_q.push_back(err);
        due_q.push_back(due);
      end
      // oldest request answers first
      // an answer due now shows in the next cycle
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        rvalid_o <= 1'b1;
        rdata_o  <= data_q.pop_front();
        err_o    <= err_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        rvalid_o <= 1'b0;
        err_o    <= 1'b0;
      end
    end
  end

endmodule

//--- bench/tb_vmem_subsys.sv
`timescale 1ns/100ps

module tb_vmem_subsys
  import mem_bus_pkg::*;
  import host_port_pkg::*;
();

  localparam int unsigned      Timeout = 100;
  localparam logic [31:0]      Seed    = 32'h35e59199;
  localparam logic [AddrW-1:0] ErrLo   = 32'h0000_F000;
  localparam logic [AddrW-1:0] ErrHi   = 32'h0000_FFFF;

  typedef enum int {SGnt, SRvalid, VGnt, VRvalid, FGnt, FDrained} wait_sel_e;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             fetch_req_i;
  logic [AddrW-1:0] fetch_addr_i;
  logic             fetch_gnt_o;
  logic             fetch_rvalid_o;
  logic [WordW-1:0] fetch_rdata_o;
  logic             fetch_err_o;
  logic             sdata_req_i;
  scalar_req_t      sdata_i;
  logic             sdata_gnt_o;
  logic             sdata_rvalid_o;
  logic [WordW-1:0] sdata_rdata_o;
  logic             sdata_err_o;
  logic             vdata_req_i;
  vec_req_t         vdata_i;
  logic             vdata_gnt_o;
  logic             vdata_rvalid_o;
  logic [MemW-1:0]  vdata_rdata_o;
  logic [VIdW-1:0]  vdata_id_o;
  logic             vdata_err_o;
  logic             vect_pending_load_i;
  logic             vect_pending_store_i;
  logic             mem_req_o;
  mem_req_t         mem_o;
  logic             mem_rvalid_i;
  logic             mem_err_i;
  logic [MemW-1:0]  mem_rdata_i;

  // expected responses
  logic [MemW-1:0]      shadow [logic [AddrW-1:0]];
  logic [WordW-1:0]     s_exp_data;
  logic                 s_exp_we;
  logic                 s_exp_err;
  logic [MemW-1:0]      v_exp_data;
  logic [VIdW-1:0]      v_exp_id;
  logic                 v_exp_we;
  logic                 v_exp_err;
  logic [WordW-1:0]     f_exp_data [OrderDepth];
  logic                 f_exp_err [OrderDepth];
  logic [OrderCntW-1:0] f_wr_q;
  logic [OrderCntW-1:0] f_rd_q;
  logic [WordW-1:0]     f_head_data;
  logic                 f_head_err;
  int                   s_gnt_cnt;
  int                   s_rv_cnt;
  int                   v_gnt_cnt;
  int                   v_rv_cnt;
  int                   f_gnt_cnt;
  int                   f_rv_cnt;
  logic [31:0]          lfsr_q;
  string                test_name;

  always #4 clk_i = ~clk_i;

  vmem_subsys_top dut (.*);

  tb_mem_model u_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (mem_req_o),
    .mem_i    (mem_o),
    .rvalid_o (mem_rvalid_i),
    .rdata_o  (mem_rdata_i),
    .err_o    (mem_err_i)
  );

  //////////////////////////////////////////////////
  // helpers

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    abort_run($sformatf("mismatch %s %s: expected %h actual %h", test_name, what, exp, act));
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic in_err_window(input logic [AddrW-1:0] a);
    return (a >= ErrLo) && (a <= ErrHi);
  endfunction

  function automatic logic [MemW-1:0] read_shadow(input logic [AddrW-1:0] a);
    logic [AddrW-1:0] wa;
    wa = {a[AddrW-1:3], 3'b000};
    if (shadow.exists(wa)) begin
      return shadow[wa];
    end
    // untouched words hold a pattern of their own address
    return {~wa, wa};
  endfunction

  function automatic logic watched(input wait_sel_e sel);
    case (sel)
      SGnt:    return sdata_gnt_o;
      SRvalid: return sdata_rvalid_o;
      VGnt:    return vdata_gnt_o;
      VRvalid: return vdata_rvalid_o;
      FGnt:    return fetch_gnt_o;
      default: return f_rv_cnt == f_gnt_cnt;
    endcase
  endfunction

  task automatic wait_for(input wait_sel_e sel, input string what);
    int unsigned n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!watched(sel) && n < Timeout);
    if (!watched(sel)) begin
      abort_run($sformatf("timed out waiting for %s in %s", what, test_name));
    end
  endtask

  task automatic scalar_access(input logic we, input logic [AddrW-1:0] addr,
                               input logic [WordBeW-1:0] be, input logic [WordW-1:0] wdata);
    @(posedge clk_i);
    sdata_req_i <= 1'b1;
    sdata_i     <= '{addr: addr, we: we, be: be, wdata: wdata};
    wait_for(SGnt, "scalar grant");
    sdata_req_i  <= 1'b0;
    // idle payload points at the other lane
    sdata_i.addr <= addr ^ AddrW'(4);
    wait_for(SRvalid, "scalar response");
  endtask

  task automatic vector_access(input logic we, input logic [AddrW-1:0] addr,
                               input logic [MemBeW-1:0] be, input logic [MemW-1:0] wdata);
    logic [VIdW-1:0] id;
    id = VIdW'(rand_bits(VIdW));
    @(posedge clk_i);
    vdata_req_i <= 1'b1;
    vdata_i     <= '{addr: addr, we: we, be: be, wdata: wdata, id: id};
    wait_for(VGnt, "vector grant");
    vdata_req_i <= 1'b0;
    // idle payload carries a different id
    vdata_i.id  <= ~id;
    wait_for(VRvalid, "vector response");
  endtask

  // back to back fetches, several in flight
  task automatic fetch_burst(input logic [AddrW-1:0] base, input int count);
    @(posedge clk_i);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= base;
    for (int k = 1; k <= count; k++) begin
      wait_for(FGnt, "fetch grant");
      fetch_addr_i <= base + AddrW'(4 * k);
    end
    fetch_req_i <= 1'b0;
    wait_for(FDrained, "fetch responses");
  endtask

  //////////////////////////////////////////////////
  // shadow memory and expected values

  always @(posedge clk_i or negedge rst_ni) begin : monitor
    logic [MemW-1:0] w;
    int              lane;
    if (!rst_ni) begin
      s_gnt_cnt <= 0;
      s_rv_cnt  <= 0;
      v_gnt_cnt <= 0;
      v_rv_cnt  <= 0;
      f_gnt_cnt <= 0;
      f_rv_cnt  <= 0;
      f_wr_q    <= '0;
      f_rd_q    <= '0;
    end else begin
      if (sdata_gnt_o) begin
        w    = read_shadow(sdata_i.addr);
        lane = int'(sdata_i.addr[2]);
        if (sdata_i.we && !in_err_window(sdata_i.addr)) begin
          for (int b = 0; b < WordBeW; b++) begin
            if (sdata_i.be[b]) begin
              w[lane*32 + b*8 +: 8] = sdata_i.wdata[b*8 +: 8];
            end
          end
          shadow[{sdata_i.addr[AddrW-1:3], 3'b000}] = w;
        end
        s_exp_data <= w[lane*32 +: 32];
        s_exp_we   <= sdata_i.we;
        s_exp_err  <= in_err_window(sdata_i.addr);
        s_gnt_cnt  <= s_gnt_cnt + 1;
      end
      if (vdata_gnt_o) begin
        w = read_shadow(vdata_i.addr);
        if (vdata_i.we && !in_err_window(vdata_i.addr)) begin
          for (int b = 0; b < MemBeW; b++) begin
            if (vdata_i.be[b]) begin
              w[b*8 +: 8] = vdata_i.wdata[b*8 +: 8];
            end
          end
          shadow[{vdata_i.addr[AddrW-1:3], 3'b000}] = w;
        end
        v_exp_data <= w;
        v_exp_id   <= vdata_i.id;
        v_exp_we   <= vdata_i.we;
        v_exp_err  <= in_err_window(vdata_i.addr);
        v_gnt_cnt  <= v_gnt_cnt + 1;
      end
      if (fetch_gnt_o) begin
        w                  = read_shadow(fetch_addr_i);
        f_exp_data[f_wr_q] <= w[int'(fetch_addr_i[2])*32 +: 32];
        f_exp_err[f_wr_q]  <= in_err_window(fetch_addr_i);
        f_wr_q             <= f_wr_q + 1'b1;
        f_gnt_cnt          <= f_gnt_cnt + 1;
      end
      if (fetch_rvalid_o) begin
        f_rd_q   <= f_rd_q + 1'b1;
        f_rv_cnt <= f_rv_cnt + 1;
      end
      if (sdata_rvalid_o) begin
        s_rv_cnt <= s_rv_cnt + 1;
      end
      if (vdata_rvalid_o) begin
        v_rv_cnt <= v_rv_cnt + 1;
      end
    end
  end

  // oldest fetch still in flight
  assign f_head_data = f_exp_data[f_rd_q];
  assign f_head_err  = f_exp_err[f_rd_q];

  //////////////////////////////////////////////////
  // checks

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    sdata_gnt_o |->
      !(vdata_req_i || vect_pending_store_i || (vect_pending_load_i && sdata_i.we)))
    else abort_run("scalar access granted while a vector hold was active");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_gnt_o |-> !(sdata_gnt_o || vdata_gnt_o))
    else abort_run("fetch granted in the same cycle as a data access");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({sdata_rvalid_o, vdata_rvalid_o, fetch_rvalid_o}) &&
    (mem_rvalid_i == (sdata_rvalid_o | vdata_rvalid_o | fetch_rvalid_o)))
    else abort_run("memory response did not reach exactly one port");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    sdata_rvalid_o && !s_exp_we && !s_exp_err |-> sdata_rdata_o == s_exp_data)
    else value_mismatch("scalar rdata", 64'($sampled(s_exp_data)),
                        64'($sampled(sdata_rdata_o)));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    sdata_rvalid_o |-> sdata_err_o == s_exp_err)
    else value_mismatch("scalar err", 64'($sampled(s_exp_err)), 64'($sampled(sdata_err_o)));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    vdata_rvalid_o && !v_exp_we && !v_exp_err |-> vdata_rdata_o == v_exp_data)
    else value_mismatch("vector rdata", $sampled(v_exp_data), $sampled(vdata_rdata_o));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    vdata_rvalid_o |-> vdata_id_o == v_exp_id)
    else value_mismatch("vector id", 64'($sampled(v_exp_id)), 64'($sampled(vdata_id_o)));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    vdata_rvalid_o |-> vdata_err_o == v_exp_err)
    else value_mismatch("vector err", 64'($sampled(v_exp_err)), 64'($sampled(vdata_err_o)));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rvalid_o && !f_head_err |-> fetch_rdata_o == f_head_data)
    else value_mismatch("fetch rdata", 64'($sampled(f_head_data)),
                        64'($sampled(fetch_rdata_o)));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rvalid_o |-> fetch_err_o == f_head_err)
    else value_mismatch("fetch err", 64'($sampled(f_head_err)), 64'($sampled(fetch_err_o)));

  //////////////////////////////////////////////////
  // stimulus

  initial begin
    rst_ni               = 1'b0;
    fetch_req_i          = 1'b0;
    fetch_addr_i         = '0;
    sdata_req_i          = 1'b0;
    sdata_i              = '0;
    vdata_req_i          = 1'b0;
    vdata_i              = '0;
    vect_pending_load_i  = 1'b0;
    vect_pending_store_i = 1'b0;
    lfsr_q               = Seed;
    test_name            = "reset";
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // full words first, later reads only touch written words
    test_name = "vector write read";
    for (int k = 0; k < 8; k++) begin
      vector_access(1'b1, AddrW'(32'h100 + 8 * k), '1, rand_bits(64));
    end
    for (int k = 0; k < 8; k++) begin
      vector_access(1'b0, AddrW'(32'h100 + 8 * k), '0, '0);
    end

    test_name = "scalar lanes";
    scalar_access(1'b1, 32'h100, 4'b1111, 32'hcafe_0001);
    scalar_access(1'b1, 32'h10c, 4'b0110, 32'h5a5a_a5a5);
    for (int k = 0; k < 4; k++) begin
      scalar_access(1'b0, AddrW'(32'h100 + 4 * k), 4'hf, '0);
    end
    // other lane bytes must be untouched
    vector_access(1'b0, 32'h100, '0, '0);
    vector_access(1'b0, 32'h108, '0, '0);

    test_name = "hold on vector request";
    fork
      vector_access(1'b1, 32'h110, 8'h0f, rand_bits(64));
      scalar_access(1'b0, 32'h110, 4'hf, '0);
    join

    test_name = "hold on pending store";
    vect_pending_store_i <= 1'b1;
    fork
      scalar_access(1'b0, 32'h118, 4'hf, '0);
      begin
        repeat (6) @(posedge clk_i);
        vect_pending_store_i <= 1'b0;
      end
    join

    test_name = "scalar write under pending load";
    vect_pending_load_i <= 1'b1;
    fork
      scalar_access(1'b1, 32'h11c, 4'hf, 32'h1234_5678);
      begin
        repeat (6) @(posedge clk_i);
        vect_pending_load_i <= 1'b0;
      end
    join

    // must be granted while the load stays pending
    test_name = "scalar read under pending load";
    vect_pending_load_i <= 1'b1;
    scalar_access(1'b0, 32'h11c, 4'hf, '0);
    vect_pending_load_i <= 1'b0;

    test_name = "fetch order";
    fetch_burst(32'h100, 12);

    test_name = "fetch against data";
    fork
      fetch_burst(32'h120, 6);
      vector_access(1'b0, 32'h128, '0, '0);
      scalar_access(1'b0, 32'h134, 4'hf, '0);
    join

    test_name = "error window";
    scalar_access(1'b0, 32'h0000_f004, 4'hf, '0);
    scalar_access(1'b1, 32'h0000_f010, 4'hf, 32'hdead_beef);
    vector_access(1'b0, 32'h0000_f008, '0, '0);
    vector_access(1'b1, 32'h0000_fff8, '1, rand_bits(64));
    fetch_burst(32'h0000_f000, 2);
    scalar_access(1'b0, 32'h104, 4'hf, '0);

    test_name = "final counts";
    repeat (2) @(posedge clk_i);
    if (s_gnt_cnt != s_rv_cnt) begin
      value_mismatch("scalar rvalid count", 64'(s_gnt_cnt), 64'(s_rv_cnt));
    end else if (v_gnt_cnt != v_rv_cnt) begin
      value_mismatch("vector rvalid count", 64'(v_gnt_cnt), 64'(v_rv_cnt));
    end else if (f_gnt_cnt != f_rv_cnt) begin
      value_mismatch("fetch rvalid count", 64'(f_gnt_cnt), 64'(f_rv_cnt));
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

//--- verilog.f
rtl/mem_bus_pkg.sv
rtl/host_port_pkg.sv
rtl/scalar_lane_adapter.sv
rtl/data_arbiter.sv
rtl/req_order_queue.sv
rtl/mem_port_arbiter.sv
rtl/vmem_subsys_top.sv
bench/tb_mem_model.sv
bench/tb_vmem_subsys.sv

//--- Bender.yml
package:
  name: vmem_subsys

sources:
  - rtl/mem_bus_pkg.sv
  - rtl/host_port_pkg.sv
  - rtl/scalar_lane_adapter.sv
  - rtl/data_arbiter.sv
  - rtl/req_order_queue.sv
  - rtl/mem_port_arbiter.sv
  - rtl/vmem_subsys_top.sv
  - target: test
    files:
      - bench/tb_mem_model.sv
      - bench/tb_vmem_subsys.sv
